// File: fetch_subsystem.f
source/mem_bus_pkg.sv
source/fetch_pkg.sv
source/burst_memory.sv
source/bus_arbiter.sv
source/data_access_port.sv
source/inst_fetch_unit.sv
source/fetch_top.sv
testbench/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fetch_tb -f fetch_subsystem.f -o fetch_sim \
  && ./obj_dir/fetch_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: testbench/fetch_tb.sv
`default_nettype none

module fetch_tb;
  import mem_bus_pkg::*;
  import fetch_pkg::*;

  localparam pc_t reset_pc    = 32'h0000_0000;
  localparam int  index_bits  = 3;
  localparam int  mem_words   = 256;
  localparam int  word_bits   = $clog2(mem_words);
  localparam int  ack_limit   = 200; // cycles
  localparam int  fetch_limit = 400;

  logic       clock;
  logic       reset;
  logic       redirect_valid;
  pc_t        redirect_pc;
  logic       invalidate;
  logic       fetch_valid;
  fetch_out_t fetch_out;
  logic       fetch_ready;
  logic       data_req;
  bus_req_t   data_cmd;
  logic       data_ack;
  word_t      data_rdata;

  word_t      shadow [mem_words]; // mirrors data port writes
  word_t      refill [mem_words]; // memory contents at the last line refill
  pc_t        expected_pc;
  word_t      expected_inst;
  fetch_out_t out_q;
  logic       ack_q;
  int         errors;
  int         timeouts;
  int         tests_run;
  int         tests_failed;

  fetch_top #(
    .reset_pc   (reset_pc),
    .index_bits (index_bits),
    .mem_words  (mem_words)
  ) i_fetch_top (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .invalidate     (invalidate),
    .fetch_valid    (fetch_valid),
    .fetch_out      (fetch_out),
    .fetch_ready    (fetch_ready),
    .data_req       (data_req),
    .data_cmd       (data_cmd),
    .data_ack       (data_ack),
    .data_rdata     (data_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic int word_index(addr_t a);
    return int'(a[2 +: word_bits]); // memory wraps at its depth
  endfunction

  function automatic addr_t random_addr();
    return addr_t'($urandom_range(mem_words - 1) * 4);
  endfunction

  assign expected_inst = refill[word_index(expected_pc)];

  always_ff @(posedge clock) begin
    out_q <= fetch_out;
    if (reset) begin
      expected_pc <= reset_pc;
      ack_q       <= 1'b0;
      for (int i = 0; i < mem_words; i++) begin
        shadow[i] <= '0;
        refill[i] <= '0;
      end
    end else begin
      ack_q <= data_ack;
      if (redirect_valid) expected_pc <= redirect_pc;
      else if (fetch_valid && fetch_ready) expected_pc <= expected_pc + 32'd4;
      if (data_ack && !ack_q && data_cmd.write) begin
        shadow[word_index(data_cmd.addr)] <= data_cmd.wdata;
      end
      // a burst on the memory side is always a line refill
      if (i_fetch_top.s_req_valid && i_fetch_top.s_req_ready && i_fetch_top.s_req.burst) begin
        refill[word_index(i_fetch_top.s_req.addr) & ~1] <=
          shadow[word_index(i_fetch_top.s_req.addr) & ~1];
        refill[word_index(i_fetch_top.s_req.addr) | 1] <=
          shadow[word_index(i_fetch_top.s_req.addr) | 1];
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    fetch_valid && fetch_ready |-> fetch_out.pc == expected_pc)
    else begin
      errors++;
      $display("** Error at %0t: fetch_out.pc = %h, expected %h",
               $time, $sampled(fetch_out.pc), $sampled(expected_pc));
    end

  assert property (@(posedge clock) disable iff (reset)
    fetch_valid && fetch_ready |-> fetch_out.inst == expected_inst)
    else begin
      errors++;
      $display("** Error at %0t: fetch_out.inst = %h, expected %h",
               $time, $sampled(fetch_out.inst), $sampled(expected_inst));
    end

  // stalled decoder
  assert property (@(posedge clock) disable iff (reset)
    fetch_valid && !fetch_ready && !redirect_valid |=> fetch_valid && $stable(fetch_out))
    else begin
      errors++;
      $display("** Error at %0t: fetch_out = %h, expected held %h",
               $time, $sampled(fetch_out), $sampled(out_q));
    end

  assert property (@(posedge clock) disable iff (reset) redirect_valid |=> !fetch_valid)
    else begin
      errors++;
      $display("** Error at %0t: fetch_valid = %b after redirect, expected 0",
               $time, $sampled(fetch_valid));
    end

  assert property (@(posedge clock) disable iff (reset) $rose(data_ack) |-> data_req)
    else begin
      errors++;
      $display("** Error at %0t: data_req = %b at data_ack rise, expected 1",
               $time, $sampled(data_req));
    end

  assert property (@(posedge clock) disable iff (reset) data_ack && data_req |=> data_ack)
    else begin
      errors++;
      $display("** Error at %0t: data_ack = %b while data_req held, expected 1",
               $time, $sampled(data_ack));
    end

  assert property (@(posedge clock) disable iff (reset) data_ack && !data_req |=> !data_ack)
    else begin
      errors++;
      $display("** Error at %0t: data_ack = %b after data_req fell, expected 0",
               $time, $sampled(data_ack));
    end

  assert property (@(posedge clock) disable iff (reset)
    $rose(data_ack) && !data_cmd.write |-> data_rdata == shadow[word_index(data_cmd.addr)])
    else begin
      errors++;
      $display("** Error at %0t: data_rdata = %h, expected %h",
               $time, $sampled(data_rdata), shadow[word_index(data_cmd.addr)]);
    end

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout at %0t: %s", $time, what);
  endtask

  task automatic close_test(input string name, input int e0, input int t0);
    tests_run++;
    if (errors == e0 && timeouts == t0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  // one four-phase transaction on the data port
  task automatic run_data_cmd(input logic cmd_write, input addr_t cmd_addr,
                              input word_t cmd_wdata);
    int waited;
    @(posedge clock);
    data_req <= 1'b1;
    data_cmd <= '{addr: cmd_addr, write: cmd_write, wdata: cmd_wdata, burst: 1'b0};
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!data_ack && waited < ack_limit);
    if (!data_ack) note_timeout($sformatf("data_ack never rose for address %h", cmd_addr));
    @(posedge clock);
    data_req <= 1'b0;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (data_ack && waited < 4);
    if (data_ack) note_timeout("data_ack stayed high after data_req fell");
  endtask

  task automatic send_redirect(input pc_t target);
    @(posedge clock);
    redirect_valid <= 1'b1;
    redirect_pc    <= target;
    @(posedge clock);
    redirect_valid <= 1'b0;
  endtask

  task automatic send_invalidate();
    @(posedge clock);
    invalidate <= 1'b1;
    @(posedge clock);
    invalidate <= 1'b0;
  endtask

  // accept exactly one instruction while ready is otherwise held low
  task automatic take_one(output fetch_out_t got);
    int waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!fetch_valid && waited < fetch_limit);
    if (!fetch_valid) note_timeout("fetch_valid never rose");
    got = fetch_out;
    @(posedge clock);
    fetch_ready <= 1'b1;
    @(posedge clock);
    fetch_ready <= 1'b0;
  endtask

  task automatic count_accepts(input int wanted, input int limit, input logic jitter);
    int seen;
    int waited;
    seen   = 0;
    waited = 0;
    while (seen < wanted && waited < limit) begin
      if (jitter) begin
        @(posedge clock);
        fetch_ready <= 1'($urandom_range(1));
      end
      @(negedge clock);
      waited++;
      if (fetch_valid && fetch_ready) seen++;
    end
    if (seen < wanted) note_timeout($sformatf("only %0d of %0d instructions taken", seen, wanted));
  endtask

  task automatic data_round_trip();
    int e0;
    int t0;
    e0 = errors;
    t0 = timeouts;
    for (int i = 0; i < mem_words; i++) run_data_cmd(1'b1, addr_t'(i * 4), $urandom());
    repeat (32) run_data_cmd(1'b0, random_addr(), '0);
    close_test("data round trip", e0, t0);
  endtask

  task automatic sequential_fetch();
    int e0;
    int t0;
    e0 = errors;
    t0 = timeouts;
    send_invalidate();
    send_redirect(32'h0000_0040);
    @(posedge clock);
    fetch_ready <= 1'b1;
    count_accepts(40, fetch_limit * 4, 1'b0);
    close_test("sequential fetch", e0, t0);
  endtask

  task automatic redirect_check();
    int e0;
    int t0;
    e0 = errors;
    t0 = timeouts;
    repeat (8) begin
      repeat ($urandom_range(5)) @(posedge clock); // lands mid refill now and then
      send_redirect(random_addr());
      count_accepts(3, fetch_limit, 1'b0);
    end
    close_test("redirect", e0, t0);
  endtask

  task automatic hit_vs_invalidate();
    int         e0;
    int         t0;
    addr_t      target;
    word_t      old_word;
    word_t      new_word;
    fetch_out_t got;
    e0     = errors;
    t0     = timeouts;
    target = 32'h0000_02a0; // even word, so the next fetch stays in the line
    @(posedge clock);
    fetch_ready <= 1'b0;
    send_redirect(target);
    take_one(got);
    old_word = shadow[word_index(target)];
    new_word = ~old_word;
    run_data_cmd(1'b1, target, new_word);
    send_redirect(target);
    take_one(got);
    assert (got.inst == old_word) else begin
      errors++;
      $display("** Error at %0t: fetch_out.inst = %h, expected cached %h",
               $time, got.inst, old_word);
    end
    send_invalidate();
    send_redirect(target);
    take_one(got);
    assert (got.inst == new_word) else begin
      errors++;
      $display("** Error at %0t: fetch_out.inst = %h, expected refilled %h",
               $time, got.inst, new_word);
    end
    close_test("cache hit versus invalidate", e0, t0);
  endtask

  task automatic back_pressure();
    int e0;
    int t0;
    e0 = errors;
    t0 = timeouts;
    send_invalidate();
    send_redirect(32'h0000_0010);
    count_accepts(48, fetch_limit * 8, 1'b1);
    @(posedge clock);
    fetch_ready <= 1'b0;
    close_test("back-pressure", e0, t0);
  endtask

  task automatic contention();
    int e0;
    int t0;
    e0 = errors;
    t0 = timeouts;
    send_invalidate();
    send_redirect(32'h0000_0100);
    @(posedge clock);
    fetch_ready <= 1'b1;
    fork
      begin
        repeat (24) run_data_cmd(1'b0, random_addr(), '0);
      end
      count_accepts(64, fetch_limit * 5, 1'b0);
    join
    @(posedge clock);
    fetch_ready <= 1'b0;
    close_test("contention", e0, t0);
  endtask

  initial begin
    void'($urandom(32'h1b27));
    errors         = 0;
    timeouts       = 0;
    tests_run      = 0;
    tests_failed   = 0;
    reset          <= 1'b1;
    redirect_valid <= 1'b0;
    redirect_pc    <= '0;
    invalidate     <= 1'b0;
    fetch_ready    <= 1'b0;
    data_req       <= 1'b0;
    data_cmd       <= '0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    data_round_trip();
    sequential_fetch();
    redirect_check();
    hit_vs_invalidate();
    back_pressure();
    contention();

    $display("tests run %0d, failed %0d, assertion errors %0d, timeouts %0d",
             tests_run, tests_failed, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`default_nettype none

module fetch_top #(
  parameter fetch_pkg::pc_t reset_pc   = 32'h0000_0000,
  parameter int             index_bits = 3,
  parameter int             mem_words  = 256
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  redirect_valid,
  input  wire fetch_pkg::pc_t        redirect_pc,
  input  wire logic                  invalidate,
  output logic                       fetch_valid,
  output fetch_pkg::fetch_out_t      fetch_out,
  input  wire logic                  fetch_ready,
  input  wire logic                  data_req,
  input  wire mem_bus_pkg::bus_req_t data_cmd,
  output logic                       data_ack,
  output mem_bus_pkg::word_t         data_rdata
);
  import mem_bus_pkg::*;

  wire [num_masters-1:0] m_req_valid;
  wire [num_masters-1:0] m_req_ready;
  wire [num_masters-1:0] m_rsp_valid;
  wire [num_masters-1:0] m_rsp_ready;
  wire bus_req_t         m_req [num_masters];
  wire bus_rsp_t         m_rsp;
  wire                   s_req_valid;
  wire                   s_req_ready;
  wire                   s_rsp_valid;
  wire                   s_rsp_ready;
  wire bus_req_t         s_req;
  wire bus_rsp_t         s_rsp;

  // master 0
  data_access_port i_data_access_port (
    .clock         (clock),
    .reset         (reset),
    .data_req      (data_req),
    .data_cmd      (data_cmd),
    .data_ack      (data_ack),
    .data_rdata    (data_rdata),
    .bus_req_valid (m_req_valid[0]),
    .bus_req       (m_req[0]),
    .bus_req_ready (m_req_ready[0]),
    .bus_rsp_valid (m_rsp_valid[0]),
    .bus_rsp       (m_rsp),
    .bus_rsp_ready (m_rsp_ready[0])
  );

  // master 1
  inst_fetch_unit #(
    .reset_pc   (reset_pc),
    .index_bits (index_bits)
  ) i_inst_fetch_unit (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .invalidate     (invalidate),
    .fetch_valid    (fetch_valid),
    .fetch_out      (fetch_out),
    .fetch_ready    (fetch_ready),
    .bus_req_valid  (m_req_valid[1]),
    .bus_req        (m_req[1]),
    .bus_req_ready  (m_req_ready[1]),
    .bus_rsp_valid  (m_rsp_valid[1]),
    .bus_rsp        (m_rsp),
    .bus_rsp_ready  (m_rsp_ready[1])
  );

  bus_arbiter i_bus_arbiter (
    .clock       (clock),
    .reset       (reset),
    .m_req_valid (m_req_valid),
    .m_req       (m_req),
    .m_req_ready (m_req_ready),
    .m_rsp_valid (m_rsp_valid),
    .m_rsp       (m_rsp),
    .m_rsp_ready (m_rsp_ready),
    .s_req_valid (s_req_valid),
    .s_req       (s_req),
    .s_req_ready (s_req_ready),
    .s_rsp_valid (s_rsp_valid),
    .s_rsp       (s_rsp),
    .s_rsp_ready (s_rsp_ready)
  );

  burst_memory #(
    .mem_words (mem_words)
  ) i_burst_memory (
    .clock     (clock),
    .reset     (reset),
    .req_valid (s_req_valid),
    .req       (s_req),
    .req_ready (s_req_ready),
    .rsp_valid (s_rsp_valid),
    .rsp       (s_rsp),
    .rsp_ready (s_rsp_ready)
  );

endmodule

`default_nettype wire

// File: source/inst_fetch_unit.sv
`default_nettype none

module inst_fetch_unit #(
  parameter fetch_pkg::pc_t reset_pc   = 32'h0000_0000,
  parameter int             index_bits = 3
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  redirect_valid,
  input  wire fetch_pkg::pc_t        redirect_pc,
  input  wire logic                  invalidate,
  output logic                       fetch_valid,
  output fetch_pkg::fetch_out_t      fetch_out,
  input  wire logic                  fetch_ready,
  output logic                       bus_req_valid,
  output mem_bus_pkg::bus_req_t      bus_req,
  input  wire logic                  bus_req_ready,
  input  wire logic                  bus_rsp_valid,
  input  wire mem_bus_pkg::bus_rsp_t bus_rsp,
  output logic                       bus_rsp_ready
);
  import fetch_pkg::*;

  localparam int lines    = 1 << index_bits;
  localparam int tag_bits = 32 - index_bits - line_offset_bits;

  typedef enum logic [1:0] {lookup, request, receive, drain} state_t;

  state_t                state;
  pc_t                   pc;
  pc_t                   line_addr; // line being refilled
  logic                  flush_pending;
  logic                  refill_void;
  logic [lines-1:0]      line_valid;
  logic [tag_bits-1:0]   line_tag [lines];
  inst_t                 line_data [lines][2];
  logic [index_bits-1:0] pc_index;
  logic [index_bits-1:0] fill_index;
  logic [tag_bits-1:0]   pc_tag;
  logic                  hit;
  logic                  slot_free;
  logic                  rsp_fire;

  assign pc_index   = pc[line_offset_bits +: index_bits];
  assign pc_tag     = pc[31 -: tag_bits];
  assign fill_index = line_addr[line_offset_bits +: index_bits];
  assign hit        = line_valid[pc_index] && (line_tag[pc_index] == pc_tag);
  assign slot_free  = !fetch_valid || fetch_ready;
  assign rsp_fire   = bus_rsp_valid && bus_rsp_ready;

  assign bus_req_valid = (state == request);
  assign bus_req       = '{addr: line_addr, write: 1'b0, wdata: '0, burst: 1'b1};
  assign bus_rsp_ready = (state == receive) || (state == drain);

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= lookup;
      pc            <= reset_pc;
      line_addr     <= '0;
      fetch_valid   <= 1'b0;
      flush_pending <= 1'b0;
      refill_void   <= 1'b0;
      line_valid    <= '0;
    end else begin
      case (state)
        lookup: begin
          if (redirect_valid) begin
            pc          <= redirect_pc;
            fetch_valid <= 1'b0;
          end else if (slot_free) begin
            if (hit) begin
              fetch_out.pc   <= pc;
              fetch_out.inst <= line_data[pc_index][pc[2]];
              fetch_valid    <= 1'b1;
              pc             <= pc + 32'd4;
            end else begin
              fetch_valid          <= 1'b0;
              line_valid[pc_index] <= 1'b0; // line is about to be overwritten
              line_addr            <= {pc[31:line_offset_bits], {line_offset_bits{1'b0}}};
              flush_pending        <= 1'b0;
              refill_void          <= 1'b0;
              state                <= request;
            end
          end
        end
        request: begin
          if (redirect_valid) begin
            pc            <= redirect_pc;
            flush_pending <= 1'b1;
          end
          if (invalidate) refill_void <= 1'b1;
          if (bus_req_ready) state <= (flush_pending || redirect_valid) ? drain : receive;
        end
        receive: begin
          if (invalidate) refill_void <= 1'b1;
          if (rsp_fire && bus_rsp.last) begin
            line_valid[fill_index] <= !refill_void;
            state                  <= lookup;
            if (redirect_valid) begin
              pc <= redirect_pc;
            end else begin
              fetch_out.pc   <= pc;
              fetch_out.inst <= pc[2] ? bus_rsp.rdata : line_data[fill_index][0];
              fetch_valid    <= 1'b1;
              pc             <= pc + 32'd4;
            end
          end else if (redirect_valid) begin
            pc    <= redirect_pc;
            state <= drain; // let the burst finish, drop its data
          end
        end
        drain: begin
          if (redirect_valid) pc <= redirect_pc;
          if (rsp_fire && bus_rsp.last) state <= lookup;
        end
      endcase
      if (invalidate) line_valid <= '0;
    end
  end

  // even word first, last flags the odd one
  always_ff @(posedge clock) begin
    if (state == receive && rsp_fire) begin
      line_data[fill_index][bus_rsp.last] <= bus_rsp.rdata;
      if (bus_rsp.last) line_tag[fill_index] <= line_addr[31 -: tag_bits];
    end
  end

  // decoder stall must hold the instruction
  assert property (@(posedge clock) disable iff (reset)
    fetch_valid && !fetch_ready |=> $stable(fetch_out));

endmodule

`default_nettype wire

// File: source/data_access_port.sv
`default_nettype none

module data_access_port (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  data_req,
  input  wire mem_bus_pkg::bus_req_t data_cmd,
  output logic                       data_ack,
  output mem_bus_pkg::word_t         data_rdata,
  output logic                       bus_req_valid,
  output mem_bus_pkg::bus_req_t      bus_req,
  input  wire logic                  bus_req_ready,
  input  wire logic                  bus_rsp_valid,
  input  wire mem_bus_pkg::bus_rsp_t bus_rsp,
  output logic                       bus_rsp_ready
);
  import mem_bus_pkg::*;

  typedef enum logic [1:0] {idle, issue, wait_rsp, ack} state_t;

  state_t   state;
  bus_req_t cmd_q;

  assign bus_req_valid = (state == issue);
  assign bus_req       = cmd_q;
  assign bus_rsp_ready = (state == wait_rsp);
  assign data_ack      = (state == ack);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle:     if (data_req) state <= issue;
        issue:    if (bus_req_ready) state <= wait_rsp;
        wait_rsp: if (bus_rsp_valid && bus_rsp.last) state <= ack;
        ack:      if (!data_req) state <= idle; // four-phase return
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == idle && data_req) begin
      cmd_q       <= data_cmd;
      cmd_q.burst <= 1'b0; // always a single beat
    end
    if (bus_rsp_valid && bus_rsp_ready) data_rdata <= bus_rsp.rdata;
  end

  assert property (@(posedge clock) disable iff (reset) $rose(data_ack) |-> data_req);

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input  wire logic                                  clock,
  input  wire logic                                  reset,
  input  wire logic [mem_bus_pkg::num_masters-1:0]   m_req_valid,
  input  wire mem_bus_pkg::bus_req_t                 m_req [mem_bus_pkg::num_masters],
  output logic [mem_bus_pkg::num_masters-1:0]        m_req_ready,
  output logic [mem_bus_pkg::num_masters-1:0]        m_rsp_valid,
  output mem_bus_pkg::bus_rsp_t                      m_rsp,
  input  wire logic [mem_bus_pkg::num_masters-1:0]   m_rsp_ready,
  output logic                                       s_req_valid,
  output mem_bus_pkg::bus_req_t                      s_req,
  input  wire logic                                  s_req_ready,
  input  wire logic                                  s_rsp_valid,
  input  wire mem_bus_pkg::bus_rsp_t                 s_rsp,
  output logic                                       s_rsp_ready
);
  import mem_bus_pkg::*;

  localparam int sel_bits = (num_masters > 1) ? $clog2(num_masters) : 1;

  typedef logic [sel_bits-1:0] sel_t;

  logic [num_masters-1:0] grant;
  logic                   busy;
  logic                   pick_valid;
  logic                   done;
  sel_t                   prio; // first master looked at
  sel_t                   pick;

  always_comb begin
    int idx;
    pick       = prio;
    pick_valid = 1'b0;
    for (int k = 0; k < num_masters; k++) begin
      idx = (int'(prio) + k) % num_masters;
      if (!pick_valid && m_req_valid[idx]) begin
        pick       = sel_t'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      grant <= '0;
      busy  <= 1'b0;
      prio  <= '0;
    end else if (!busy) begin
      if (pick_valid) begin
        grant       <= '0;
        grant[pick] <= 1'b1;
        busy        <= 1'b1;
        prio        <= sel_t'((int'(pick) + 1) % num_masters); // winner goes last
      end
    end else if (done) begin
      grant <= '0;
      busy  <= 1'b0;
    end
  end

  always_comb begin
    s_req_valid = 1'b0;
    s_req       = '0;
    s_rsp_ready = 1'b0;
    m_req_ready = '0;
    m_rsp_valid = '0;
    for (int k = 0; k < num_masters; k++) begin
      if (grant[k]) begin
        s_req_valid    = m_req_valid[k];
        s_req          = m_req[k];
        s_rsp_ready    = m_rsp_ready[k];
        m_req_ready[k] = s_req_ready;
        m_rsp_valid[k] = s_rsp_valid;
      end
    end
  end

  assign m_rsp = s_rsp; // shared, only the owner sees valid
  assign done  = s_rsp_valid && s_rsp_ready && s_rsp.last;

  assert property (@(posedge clock) disable iff (reset) $onehot0(grant));
  // a beat still pending on the memory side pins the owner
  assert property (@(posedge clock) disable iff (reset) s_rsp_valid && !done |=> $stable(grant));

endmodule

`default_nettype wire

// File: source/burst_memory.sv
`default_nettype none

module burst_memory #(
  parameter int mem_words = 256
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  req_valid,
  input  wire mem_bus_pkg::bus_req_t req,
  output logic                       req_ready,
  output logic                       rsp_valid,
  output mem_bus_pkg::bus_rsp_t      rsp,
  input  wire logic                  rsp_ready
);
  import mem_bus_pkg::*;

  localparam int index_bits = $clog2(mem_words);

  typedef logic [index_bits-1:0] index_t;

  word_t  mem [mem_words];
  index_t req_index;
  index_t next_index; // odd word of a burst
  logic   req_fire;
  logic   rsp_fire;

  assign req_ready = !rsp_valid; // idle once the last beat is gone
  assign req_fire  = req_valid && req_ready;
  assign rsp_fire  = rsp_valid && rsp_ready;
  assign req_index = req.addr[2 +: index_bits]; // wraps to the depth

  always_ff @(posedge clock) begin
    if (req_fire && req.write) mem[req_index] <= req.wdata;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rsp_valid  <= 1'b0;
      rsp        <= '0;
      next_index <= '0;
    end else if (req_fire) begin
      rsp_valid <= 1'b1;
      if (req.burst && !req.write) begin
        rsp        <= '{rdata: mem[{req_index[index_bits-1:1], 1'b0}], last: 1'b0};
        next_index <= {req_index[index_bits-1:1], 1'b1};
      end else begin
        rsp <= '{rdata: mem[req_index], last: 1'b1};
      end
    end else if (rsp_fire) begin
      if (rsp.last) begin
        rsp_valid <= 1'b0;
      end else begin
        rsp <= '{rdata: mem[next_index], last: 1'b1};
      end
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  typedef logic [31:0] pc_t;
  typedef logic [31:0] inst_t;

  // what the decoder sees
  typedef struct packed {
    pc_t   pc;
    inst_t inst;
  } fetch_out_t;

  localparam int line_offset_bits = 3; // two words per line

endpackage

`default_nettype wire

// File: source/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  typedef logic [31:0] addr_t; // byte address
  typedef logic [31:0] word_t;

  // one request beat, held by the master until accepted
  typedef struct packed {
    addr_t addr;
    logic  write;
    word_t wdata;
    logic  burst; // two-beat line read
  } bus_req_t;

  typedef struct packed {
    word_t rdata;
    logic  last;
  } bus_rsp_t;

  // master 0 is the data port, master 1 the fetch unit
  localparam int num_masters = 2;

endpackage

`default_nettype wire
